/* compile.f */
+incdir+source
source/loopFilterPkg.sv
source/errorScaler.sv
source/loopControl.sv
source/lagIntegrator.sv
source/frequencyCombiner.sv
source/loopFilter.sv
sim/loopFilter_checker.sv
sim/loopFilter_tb.sv

/* sim/loopFilter_checker.sv */
`timescale 1ns/100ps

module loopFilter_checker import loopFilterPkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       errorValid,
    input logic       freqValid,
    input limitFlagsT limitFlags,
    input sweepStateT sweepState
);

    // Number of assertion failures so far
    int failCount = 0;

    // Clamping picks one limit per update
    flagsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(limitFlags.hitUpper && limitFlags.hitLower))
        else begin
            failCount++;
            $error("Both integrator limit flags are set");
        end

    // Two register stages from error strobe to frequency word
    freqValidLatency: assert property (@(posedge clk) disable iff (reset)
        errorValid |-> ##2 freqValid)
        else begin
            failCount++;
            $error("freqValid missing two cycles after errorValid");
        end

    freqValidSource: assert property (@(posedge clk) disable iff (reset)
        freqValid |-> $past(errorValid, 2))
        else begin
            failCount++;
            $error("freqValid without errorValid two cycles earlier");
        end

    stateLegal: assert property (@(posedge clk) disable iff (reset)
        sweepState inside {sweepOff, sweepUp, sweepDown})
        else begin
            failCount++;
            $error("sweepState holds an illegal encoding");
        end

    quietInReset: assert property (@(posedge clk) reset |-> !freqValid)
        else begin
            failCount++;
            $error("freqValid high during reset");
        end

endmodule

bind loopFilter loopFilter_checker filterChecker (
    .clk        (clk),
    .reset      (reset),
    .errorValid (errorValid),
    .freqValid  (freqValid),
    .limitFlags (limitFlags),
    .sweepState (sweepState)
);

/* sim/loopFilter_tb.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module loopFilter_tb import loopFilterPkg::*; ();

    localparam int timeoutCycles = 20;

    // One strobe per row, expected flags and state seen after the update
    typedef struct packed {
        logic [`ERROR_WIDTH-1:0] error;
        logic                    useRandom;
        logic                    track;
        logic                    sync;
        logic                    clear;
        logic [2:0]              cfgIdx;
        sweepStateT              expState;
        limitFlagsT              expFlags;
    } rowT;

    logic                           clk;
    logic                           reset;
    logic                           errorValid;
    logic [`ERROR_WIDTH-1:0]        error;
    logic                           track;
    logic                           carrierInSync;
    logic                           clearAccum;
    loopConfigT                     loopConfig;
    logic [`ACCUM_WIDTH-1:0]        freq;
    logic                           freqValid;
    logic [`ACCUM_WIDTH-1:0]        lagAccum;
    limitFlagsT                     limitFlags;
    sweepStateT                     sweepState;

    // Reference model state
    logic [`ACCUM_WIDTH-1:0]        modelAccum;
    limitFlagsT                     modelFlags;
    sweepStateT                     modelState;
    logic                           modelUp;
    logic signed [`LIMIT_WIDTH-1:0] modelOffset;
    logic [31:0]                    lcgState;

    // lagExp, leadExp, acqTrackControl, upper, lower, sweepEnable, sweepRateMag
    loopConfigT configs [0:6] = '{
        '{5'd3, 5'd5, 2'd0, 32'h7FFF_FFFF, 32'h8000_0000, 1'b0, 32'd0},
        '{5'd6, 5'd7, 2'd2, 32'h7FFF_FFFF, 32'h8000_0000, 1'b0, 32'd0},
        '{5'd3, 5'd4, 2'd3, 32'h7FFF_FFFF, 32'h8000_0000, 1'b0, 32'd0},
        '{5'd20, 5'd3, 2'd0, 32'sd1000, -32'sd1000, 1'b0, 32'd0},
        '{5'd0, 5'd3, 2'd0, 32'sd1000, -32'sd1000, 1'b1, 32'd153600},
        '{5'd10, 5'd3, 2'd0, -32'sd5, 32'sd5, 1'b0, 32'd0},
        '{5'd9, 5'd9, 2'd1, 32'h7FFF_FFFF, 32'h8000_0000, 1'b0, 32'd0}
    };

    // error, useRandom, track, sync, clear, cfgIdx, expState, expFlags
    rowT rows [0:22] = '{
        '{12'h000, 1'b1, 1'b1, 1'b1, 1'b0, 3'd0, sweepOff, 2'b00},
        '{12'h000, 1'b1, 1'b1, 1'b1, 1'b0, 3'd6, sweepOff, 2'b00},
        '{12'h000, 1'b1, 1'b1, 1'b1, 1'b0, 3'd1, sweepOff, 2'b00},
        '{12'h000, 1'b1, 1'b1, 1'b1, 1'b0, 3'd2, sweepOff, 2'b00},
        '{12'h000, 1'b1, 1'b0, 1'b1, 1'b0, 3'd1, sweepOff, 2'b00},
        '{12'h7FF, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, sweepOff, 2'b10},
        '{12'h7FF, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, sweepOff, 2'b10},
        '{12'h800, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, sweepOff, 2'b01},
        '{12'h800, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, sweepOff, 2'b01},
        '{12'h7FF, 1'b0, 1'b0, 1'b1, 1'b0, 3'd5, sweepOff, 2'b00},
        '{12'h123, 1'b0, 1'b0, 1'b1, 1'b0, 3'd5, sweepOff, 2'b00},
        '{12'h000, 1'b1, 1'b0, 1'b1, 1'b1, 3'd3, sweepOff, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepUp, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepUp, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepUp, 2'b10},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepDown, 2'b10},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepDown, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b1, 1'b0, 3'd4, sweepOff, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepDown, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepDown, 2'b00},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepDown, 2'b01},
        '{12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd4, sweepUp, 2'b01},
        '{12'h000, 1'b0, 1'b0, 1'b1, 1'b0, 3'd4, sweepOff, 2'b00}
    };

    loopFilter loopFilter_inst (
        .clk           (clk),
        .reset         (reset),
        .errorValid    (errorValid),
        .error         (error),
        .track         (track),
        .carrierInSync (carrierInSync),
        .clearAccum    (clearAccum),
        .loopConfig    (loopConfig),
        .freq          (freq),
        .freqValid     (freqValid),
        .lagAccum      (lagAccum),
        .limitFlags    (limitFlags),
        .sweepState    (sweepState)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Tracking lowers the exponent but never below 1
    function automatic logic [`GAIN_WIDTH-1:0] expectedGain(
        input logic [`GAIN_WIDTH-1:0] exponent,
        input int                     reduction,
        input logic                   tracking
    );
        int candidate;
        candidate = int'(exponent) - reduction;
        if (!tracking) return exponent;
        return (candidate < 1) ? 1 : candidate[`GAIN_WIDTH-1:0];
    endfunction

    // Error times 2**(gain-3), zero for gain 0
    function automatic logic [`ACCUM_WIDTH-1:0] expectedScaled(
        input logic [`ERROR_WIDTH-1:0] err,
        input logic [`GAIN_WIDTH-1:0]  gain
    );
        logic signed [`ACCUM_WIDTH-1:0] value;
        value = $signed(err);
        if (gain == 0) return '0;
        if (gain < 3) return value >>> (3 - gain);
        return value << (gain - 3);
    endfunction

    task automatic abortRun();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareFreq(input string name, input logic [`ACCUM_WIDTH-1:0] expected,
                               input logic [`ACCUM_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareFlags(input limitFlagsT expected, input limitFlagsT actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: limitFlags expected %b actual %b",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareState(input sweepStateT expected, input sweepStateT actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: sweepState expected %0d actual %0d",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    // Assertion failures in the bound checker
    always @(posedge clk) begin
        if (loopFilter_inst.filterChecker.failCount != 0) begin
            $display("An assertion in the bound checker failed");
            abortRun();
        end
    end

    // Integrator uses the old sweep offset, the sweep uses the old flags
    task automatic modelStep(input logic [`ERROR_WIDTH-1:0] err, input loopConfigT cfg,
                             input logic trk, input logic sync, input logic clr,
                             output logic [`ACCUM_WIDTH-1:0] expFreq);
        logic [`ACCUM_WIDTH-1:0]      lead;
        logic [`ACCUM_WIDTH-1:0]      lag;
        logic signed [`ACCUM_WIDTH:0] sum;
        logic signed [`LIMIT_WIDTH:0] top;
        logic signed [`LIMIT_WIDTH:0] upper;
        logic signed [`LIMIT_WIDTH:0] lower;
        logic [`LIMIT_WIDTH-1:0]      rate;
        limitFlagsT                   oldFlags;
        lead = expectedScaled(err, expectedGain(cfg.leadExp, cfg.acqTrackControl, trk));
        lag = expectedScaled(err, expectedGain(cfg.lagExp, 2 * cfg.acqTrackControl, trk));
        oldFlags = modelFlags;
        rate = cfg.sweepRateMag;
        sum = $signed({modelAccum[`ACCUM_WIDTH-1], modelAccum})
            + $signed({lag[`ACCUM_WIDTH-1], lag}) + modelOffset;
        top = sum[`ACCUM_WIDTH:`ACCUM_WIDTH-`LIMIT_WIDTH];
        upper = cfg.upperLimit;
        lower = cfg.lowerLimit;
        if (clr) begin
            modelAccum = '0;
        end else if (upper < lower) begin
            modelFlags = '0;
        end else if (top >= upper) begin
            modelAccum = {cfg.upperLimit, {(`ACCUM_WIDTH-`LIMIT_WIDTH){1'b0}}};
            modelFlags = 2'b10;
        end else if (top <= lower) begin
            modelAccum = {cfg.lowerLimit, {(`ACCUM_WIDTH-`LIMIT_WIDTH){1'b1}}};
            modelFlags = 2'b01;
        end else begin
            modelAccum = sum[`ACCUM_WIDTH-1:0];
            modelFlags = '0;
        end
        if (!cfg.sweepEnable) begin
            modelState = sweepOff;
            modelOffset = '0;
            modelUp = 1'b1;
        end else if (modelState == sweepOff) begin
            if (!sync) begin
                modelState = modelUp ? sweepUp : sweepDown;
                modelOffset = modelUp ? rate : -rate;
            end
        end else if (sync) begin
            modelUp = (modelState == sweepUp);
            modelState = sweepOff;
            modelOffset = '0;
        end else if (modelState == sweepUp) begin
            modelState = oldFlags.hitUpper ? sweepDown : sweepUp;
            modelOffset = oldFlags.hitUpper ? -rate : rate;
        end else begin
            modelState = oldFlags.hitLower ? sweepUp : sweepDown;
            modelOffset = oldFlags.hitLower ? rate : -rate;
        end
        expFreq = lead + modelAccum;
    endtask

    // Configuration settles one cycle ahead so the registered gains follow it
    task automatic applyStrobe(input logic [`ERROR_WIDTH-1:0] err, input loopConfigT cfg,
                               input logic trk, input logic sync, input logic clr);
        logic [`ACCUM_WIDTH-1:0] expFreq;
        int                      waited;
        @(negedge clk);
        loopConfig = cfg;
        track = trk;
        carrierInSync = sync;
        @(negedge clk);
        error = err;
        clearAccum = clr;
        errorValid = 1'b1;
        @(negedge clk);
        errorValid = 1'b0;
        clearAccum = 1'b0;
        modelStep(err, cfg, trk, sync, clr, expFreq);
        waited = 0;
        while (!freqValid && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!freqValid) begin
            $display("Timeout: freqValid did not rise within %0d cycles", timeoutCycles);
            abortRun();
        end
        compareFreq("freq", expFreq, freq);
        compareFreq("lagAccum", modelAccum, lagAccum);
    endtask

    initial begin
        loopConfigT  cfg;
        logic [31:0] randomWord;
        logic [`ERROR_WIDTH-1:0] err;
        lcgState = 32'd84;
        modelAccum = '0;
        modelFlags = '0;
        modelState = sweepOff;
        modelUp = 1'b1;
        modelOffset = '0;
        reset = 1'b1;
        errorValid = 1'b0;
        error = '0;
        track = 1'b0;
        carrierInSync = 1'b1;
        clearAccum = 1'b0;
        loopConfig = configs[0];
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            randomWord = nextRandom();
            err = rows[i].useRandom ? randomWord[27:16] : rows[i].error;
            applyStrobe(err, configs[rows[i].cfgIdx], rows[i].track, rows[i].sync,
                        rows[i].clear);
            compareFlags(rows[i].expFlags, limitFlags);
            compareState(rows[i].expState, sweepState);
        end

        // Every gain code on both paths in acquisition
        for (int g = 0; g < 32; g++) begin
            cfg = configs[0];
            cfg.lagExp = g[`GAIN_WIDTH-1:0];
            cfg.leadExp = 5'd31 - g[`GAIN_WIDTH-1:0];
            randomWord = nextRandom();
            applyStrobe(randomWord[27:16], cfg, 1'b0, 1'b1, 1'b0);
            compareFlags(modelFlags, limitFlags);
            compareState(modelState, sweepState);
        end

        // Latency assertion of the last strobe resolves two cycles later
        repeat (2) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* source/errorScaler.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module errorScaler (
    input  logic [`ERROR_WIDTH-1:0] error,
    input  logic [`GAIN_WIDTH-1:0]  gain,
    output logic [`ACCUM_WIDTH-1:0] scaled
);

    // Gain code at which the error passes through unshifted
    localparam int unityGain = 3;

    logic signed [`ACCUM_WIDTH-1:0] extended;

    assign extended = {{(`ACCUM_WIDTH - `ERROR_WIDTH){error[`ERROR_WIDTH-1]}}, error};

    // Gain table
    //   0       zero
    //   1, 2    shift right, low bits truncated
    //   3..31   shift left by gain - 3, code 31 fills the word
    always_comb begin
        if (gain == '0) begin
            scaled = '0;
        end else if (gain < unityGain) begin
            scaled = extended >>> (unityGain - gain);
        end else begin
            scaled = extended << (gain - unityGain);
        end
    end

endmodule

/* source/frequencyCombiner.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module frequencyCombiner (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    errorValid,
    input  logic [`ACCUM_WIDTH-1:0] leadError,
    input  logic [`ACCUM_WIDTH-1:0] lagAccum,
    output logic [`ACCUM_WIDTH-1:0] freq,
    output logic                    freqValid
);

    logic [`ACCUM_WIDTH-1:0] leadHold;
    logic                    strobeDelay;

    // Lead term is captured alongside the integrator update
    always_ff @(posedge clk) begin
        if (errorValid) begin
            leadHold <= leadError;
        end
    end

    // One cycle later the integrator holds its new value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strobeDelay <= 1'b0;
            freqValid   <= 1'b0;
            freq        <= '0;
        end else begin
            strobeDelay <= errorValid;
            freqValid   <= strobeDelay;
            if (strobeDelay) begin
                freq <= leadHold + lagAccum;
            end
        end
    end

endmodule

/* source/lagIntegrator.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module lagIntegrator import loopFilterPkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            errorValid,
    input  logic                            clearAccum,
    input  logic [`ACCUM_WIDTH-1:0]         lagError,
    input  logic signed [`LIMIT_WIDTH-1:0]  sweepOffset,
    input  loopConfigT                      loopConfig,
    output logic [`ACCUM_WIDTH-1:0]         lagAccum,
    output limitFlagsT                      limitFlags
);

    // Fraction bits below the limit-sized integer part
    localparam int fracBits = `ACCUM_WIDTH - `LIMIT_WIDTH;

    // Sum and limits carry one guard bit so the compare never wraps
    logic signed [`ACCUM_WIDTH:0]   sum;
    logic signed [`LIMIT_WIDTH:0]   sumTop;
    logic signed [`LIMIT_WIDTH:0]   upperExt;
    logic signed [`LIMIT_WIDTH:0]   lowerExt;
    logic                           limitsInverted;
    logic [`ACCUM_WIDTH-1:0]        accumNext;
    limitFlagsT                     flagsNext;

    assign sum = $signed({lagAccum[`ACCUM_WIDTH-1], lagAccum})
               + $signed({lagError[`ACCUM_WIDTH-1], lagError})
               + $signed({{(fracBits + 1){sweepOffset[`LIMIT_WIDTH-1]}}, sweepOffset});

    assign sumTop = sum[`ACCUM_WIDTH:fracBits];
    assign upperExt = {loopConfig.upperLimit[`LIMIT_WIDTH-1], loopConfig.upperLimit};
    assign lowerExt = {loopConfig.lowerLimit[`LIMIT_WIDTH-1], loopConfig.lowerLimit};
    assign limitsInverted = upperExt < lowerExt;

    always_comb begin
        if (limitsInverted) begin
            // No usable range, hold the integrator where it is
            accumNext          = lagAccum;
            flagsNext.hitUpper = 1'b0;
            flagsNext.hitLower = 1'b0;
        end else if (sumTop >= upperExt) begin
            accumNext          = {loopConfig.upperLimit, {fracBits{1'b0}}};
            flagsNext.hitUpper = 1'b1;
            flagsNext.hitLower = 1'b0;
        end else if (sumTop <= lowerExt) begin
            // Fraction filled with ones, just above the true lower bound
            accumNext          = {loopConfig.lowerLimit, {fracBits{1'b1}}};
            flagsNext.hitUpper = 1'b0;
            flagsNext.hitLower = 1'b1;
        end else begin
            accumNext          = sum[`ACCUM_WIDTH-1:0];
            flagsNext.hitUpper = 1'b0;
            flagsNext.hitLower = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum   <= '0;
            limitFlags <= '0;
        end else if (clearAccum) begin
            lagAccum <= '0;
        end else if (errorValid) begin
            lagAccum   <= accumNext;
            limitFlags <= flagsNext;
        end
    end

endmodule

/* source/loopControl.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module loopControl import loopFilterPkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            errorValid,
    input  logic                            track,
    input  logic                            carrierInSync,
    input  loopConfigT                      loopConfig,
    input  limitFlagsT                      limitFlags,
    output logic [`GAIN_WIDTH-1:0]          lagGain,
    output logic [`GAIN_WIDTH-1:0]          leadGain,
    output logic signed [`LIMIT_WIDTH-1:0]  sweepOffset,
    output sweepStateT                      sweepState
);

    localparam logic [`GAIN_WIDTH-1:0] minGain = 1;

    // One extra bit so a reduction past zero shows up as a negative value
    logic signed [`GAIN_WIDTH:0]    lagCandidate;
    logic signed [`GAIN_WIDTH:0]    leadCandidate;
    logic [`GAIN_WIDTH-1:0]         lagNext;
    logic [`GAIN_WIDTH-1:0]         leadNext;
    logic signed [`LIMIT_WIDTH-1:0] posRate;
    logic signed [`LIMIT_WIDTH-1:0] negRate;
    logic                           sweepingUp;

    // Lag term goes with the square of the loop width, so it drops by twice the code
    assign lagCandidate = $signed({1'b0, loopConfig.lagExp})
                        - $signed({3'b000, loopConfig.acqTrackControl, 1'b0});
    assign leadCandidate = $signed({1'b0, loopConfig.leadExp})
                         - $signed({4'b0000, loopConfig.acqTrackControl});

    always_comb begin
        if (!track) begin
            lagNext  = loopConfig.lagExp;
            leadNext = loopConfig.leadExp;
        end else begin
            lagNext  = (lagCandidate < 1) ? minGain : lagCandidate[`GAIN_WIDTH-1:0];
            leadNext = (leadCandidate < 1) ? minGain : leadCandidate[`GAIN_WIDTH-1:0];
        end
    end

    // Gains follow configuration every clock
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagGain  <= '0;
            leadGain <= '0;
        end else begin
            lagGain  <= lagNext;
            leadGain <= leadNext;
        end
    end

    assign posRate = $signed(loopConfig.sweepRateMag);
    assign negRate = -$signed(loopConfig.sweepRateMag);

    // Sweep steps once per error
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sweepState  <= sweepOff;
            sweepOffset <= '0;
            sweepingUp  <= 1'b1;
        end else if (errorValid) begin
            if (!loopConfig.sweepEnable) begin
                sweepState  <= sweepOff;
                sweepOffset <= '0;
                sweepingUp  <= 1'b1;
            end else begin
                case (sweepState)
                    sweepOff: begin
                        if (carrierInSync) begin
                            sweepOffset <= '0;
                        end else if (sweepingUp) begin
                            sweepState  <= sweepUp;
                            sweepOffset <= posRate;
                        end else begin
                            sweepState  <= sweepDown;
                            sweepOffset <= negRate;
                        end
                    end
                    sweepUp: begin
                        if (carrierInSync) begin
                            sweepState  <= sweepOff;
                            sweepOffset <= '0;
                            sweepingUp  <= 1'b1;
                        end else if (limitFlags.hitUpper) begin
                            sweepState  <= sweepDown;
                            sweepOffset <= negRate;
                        end else begin
                            sweepOffset <= posRate;
                        end
                    end
                    sweepDown: begin
                        if (carrierInSync) begin
                            sweepState  <= sweepOff;
                            sweepOffset <= '0;
                            sweepingUp  <= 1'b0;
                        end else if (limitFlags.hitLower) begin
                            sweepState  <= sweepUp;
                            sweepOffset <= posRate;
                        end else begin
                            sweepOffset <= negRate;
                        end
                    end
                    default: begin
                        sweepState  <= sweepOff;
                        sweepOffset <= '0;
                        sweepingUp  <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

/* source/loopFilter.sv */
`timescale 1ns/100ps
`include "loopFilter_defines.svh"

module loopFilter import loopFilterPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    errorValid,
    input  logic [`ERROR_WIDTH-1:0] error,
    input  logic                    track,
    input  logic                    carrierInSync,
    input  logic                    clearAccum,
    input  loopConfigT              loopConfig,
    output logic [`ACCUM_WIDTH-1:0] freq,
    output logic                    freqValid,
    output logic [`ACCUM_WIDTH-1:0] lagAccum,
    output limitFlagsT              limitFlags,
    output sweepStateT              sweepState
);

    logic [`GAIN_WIDTH-1:0]         lagGain;
    logic [`GAIN_WIDTH-1:0]         leadGain;
    logic signed [`LIMIT_WIDTH-1:0] sweepOffset;
    logic [`ACCUM_WIDTH-1:0]        leadError;
    logic [`ACCUM_WIDTH-1:0]        lagError;

    loopControl control (
        .clk           (clk),
        .reset         (reset),
        .errorValid    (errorValid),
        .track         (track),
        .carrierInSync (carrierInSync),
        .loopConfig    (loopConfig),
        .limitFlags    (limitFlags),
        .lagGain       (lagGain),
        .leadGain      (leadGain),
        .sweepOffset   (sweepOffset),
        .sweepState    (sweepState)
    );

    // Proportional path
    errorScaler leadScaler (
        .error  (error),
        .gain   (leadGain),
        .scaled (leadError)
    );

    // Integral path
    errorScaler lagScaler (
        .error  (error),
        .gain   (lagGain),
        .scaled (lagError)
    );

    lagIntegrator integrator (
        .clk         (clk),
        .reset       (reset),
        .errorValid  (errorValid),
        .clearAccum  (clearAccum),
        .lagError    (lagError),
        .sweepOffset (sweepOffset),
        .loopConfig  (loopConfig),
        .lagAccum    (lagAccum),
        .limitFlags  (limitFlags)
    );

    frequencyCombiner combiner (
        .clk        (clk),
        .reset      (reset),
        .errorValid (errorValid),
        .leadError  (leadError),
        .lagAccum   (lagAccum),
        .freq       (freq),
        .freqValid  (freqValid)
    );

endmodule

/* source/loopFilterPkg.sv */
`include "loopFilter_defines.svh"

package loopFilterPkg;

    // Frequency sweep while the carrier is not in sync
    typedef enum logic [1:0] {
        sweepOff  = 2'd0,
        sweepUp   = 2'd1,
        sweepDown = 2'd2
    } sweepStateT;

    // Static loop configuration
    typedef struct packed {
        logic [`GAIN_WIDTH-1:0]         lagExp;
        logic [`GAIN_WIDTH-1:0]         leadExp;
        logic [1:0]                     acqTrackControl;
        logic signed [`LIMIT_WIDTH-1:0] upperLimit;
        logic signed [`LIMIT_WIDTH-1:0] lowerLimit;
        logic                           sweepEnable;
        logic [`LIMIT_WIDTH-1:0]        sweepRateMag;
    } loopConfigT;

    // Which integrator limit the last update ran into
    typedef struct packed {
        logic hitUpper;
        logic hitLower;
    } limitFlagsT;

endpackage

/* source/loopFilter_defines.svh */
`ifndef LOOPFILTER_DEFINES_SVH
`define LOOPFILTER_DEFINES_SVH

// Phase detector error
`define ERROR_WIDTH 12

// Gain exponent code, one entry per shift in the gain table
`define GAIN_WIDTH 5

// Integrator limits and sweep rate
`define LIMIT_WIDTH 32

// Integrator and NCO frequency word, 8 fraction bits below the limits
`define ACCUM_WIDTH 40

`endif
